// ==== Makefile ====
# Verilator build and run for the concentric circles design

VERILATOR ?= verilator
TOP       ?= tb_circles
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= all tests passed

SRCS    := $(shell grep -v '^+' $(FILELIST))
HEADERS := circles_settings.svh
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== circle_sequencer.sv ====
//##########################################################
// drawing starts on the first frame strobe after FRAME_WAIT strobes
// at most PIX_FRAME enables between two frame strobes
//##########################################################
`include "circles_settings.svh"

module circle_sequencer (
    input  logic                 clk_100m,
    input  logic                 rst_n,
    input  logic                 frame,
    input  logic                 done,
    output circles_pkg::circle_t job,
    output logic                 start,
    output logic                 oe,
    output logic                 scene_done
);
    localparam int SHAPEW = $clog2(`SHAPE_CNT);
    localparam int WAITW  = $clog2(`FRAME_WAIT + 1);
    localparam int PIXW   = $clog2(`PIX_FRAME + 1);

    circles_pkg::seq_state_e state;

    logic [SHAPEW-1:0] shape_id;
    logic [WAITW-1:0]  cnt_frame_wait;
    logic [PIXW-1:0]   cnt_pix_frame;
    logic              wait_done;

    assign wait_done  = (cnt_frame_wait == WAITW'(`FRAME_WAIT));
    assign oe         = wait_done && (cnt_pix_frame < PIXW'(`PIX_FRAME));
    assign scene_done = (state == circles_pkg::DONE);

    always_ff @(posedge clk_100m or negedge rst_n) begin
        if (!rst_n) begin
            state    <= circles_pkg::IDLE;
            shape_id <= '0;
            start    <= 1'b0;
        end else begin
            start <= 1'b0;
            case (state)
                circles_pkg::IDLE: if (frame && wait_done) state <= circles_pkg::INIT;
                circles_pkg::INIT: begin
                    start <= 1'b1;  // rasteriser is back in idle by now
                    state <= circles_pkg::DRAW;
                end
                circles_pkg::DRAW: begin
                    if (done) begin
                        if (shape_id == SHAPEW'(`SHAPE_CNT - 1)) begin
                            state <= circles_pkg::DONE;
                        end else begin
                            shape_id <= shape_id + 1'b1;
                            state    <= circles_pkg::INIT;
                        end
                    end
                end
                default: state <= circles_pkg::DONE;  // stays done
            endcase
        end
    end

    // shrinking radius per shape
    always_ff @(posedge clk_100m) begin
        if (state == circles_pkg::INIT) begin
            job.x0 <= `CORDW'(`SHAPE_X0);
            job.y0 <= `CORDW'(`SHAPE_Y0);
            job.r0 <= `CORDW'(`SHAPE_R0 - int'(shape_id) * `SHAPE_RSTEP);
        end
    end

    // frame wait and pixel budget
    always_ff @(posedge clk_100m or negedge rst_n) begin
        if (!rst_n) begin
            cnt_frame_wait <= '0;
            cnt_pix_frame  <= '0;
        end else if (frame) begin
            if (!wait_done) cnt_frame_wait <= cnt_frame_wait + 1'b1;  // saturates
            cnt_pix_frame <= '0;
        end else if (oe) begin
            cnt_pix_frame <= cnt_pix_frame + 1'b1;
        end
    end

endmodule

// ==== circles_pkg.sv ====
//##########################################################
// shared types, widths come from the settings header
// both state enums share package scope, so rasteriser states carry a prefix
//##########################################################
`include "circles_settings.svh"

package circles_pkg;

    // one circle job
    typedef struct packed {
        logic signed [`CORDW-1:0] x0;
        logic signed [`CORDW-1:0] y0;
        logic signed [`CORDW-1:0] r0;
    } circle_t;

    typedef struct packed {
        logic                     we;
        logic signed [`CORDW-1:0] x;
        logic signed [`CORDW-1:0] y;
        logic [`CIDXW-1:0]        cidx;
    } fb_write_t;

    typedef struct packed {
        logic               hsync;  // active high
        logic               vsync;  // active high
        logic               de;
        logic [`CHANW-1:0]  red;
        logic [`CHANW-1:0]  green;
        logic [`CHANW-1:0]  blue;
    } video_t;

    typedef enum logic [1:0] {IDLE, INIT, DRAW, DONE} seq_state_e;

    typedef enum logic [1:0] {CIRC_IDLE, CIRC_CORNER, CIRC_NEXT, CIRC_DONE} circle_state_e;

endpackage

// ==== circles_settings.svh ====
//##########################################################
// sizes for a simulation-sized display, one clock is the pixel clock
// radii must stay positive: SHAPE_R0 >= (SHAPE_CNT-1)*SHAPE_RSTEP
//##########################################################
`ifndef CIRCLES_SETTINGS_SVH
`define CIRCLES_SETTINGS_SVH

`define CORDW        16     // signed coordinate width

`define H_ACTIVE     64     // line is 80 pixels
`define H_FRONT      4
`define H_SYNC       8
`define H_BACK       4
`define V_ACTIVE     48     // frame is 54 lines
`define V_FRONT      2
`define V_SYNC       2
`define V_BACK       2

`define FB_WIDTH     32
`define FB_HEIGHT    24
`define FB_SCALE     2      // buffer pixel covers 2x2 screen pixels
`define CIDXW        4
`define CHANW        4

`define SHAPE_CNT    4
`define SHAPE_X0     16
`define SHAPE_Y0     12
`define SHAPE_R0     10
`define SHAPE_RSTEP  2
`define SHAPE_CIDX   12     // blue in the palette

`define FRAME_WAIT   3      // frame strobes before drawing
`define PIX_FRAME    40     // pixel enables per frame

`endif

// ==== circles_top.sv ====
//##########################################################
// single clock, clk_100m is also the pixel clock
// scene_done stays high once the last circle is drawn
//##########################################################
`include "circles_settings.svh"

module circles_top (
    input  logic                clk_100m,
    input  logic                rst_n,
    output circles_pkg::video_t video,
    output logic                scene_done
);
    logic signed [`CORDW-1:0] sx;
    logic signed [`CORDW-1:0] sy;
    logic                     hsync;
    logic                     vsync;
    logic                     de;
    logic                     frame;
    circles_pkg::circle_t     job;
    circles_pkg::fb_write_t   wr;
    logic                     start;
    logic                     oe;
    logic                     done;

    display_timing display_inst (
        .clk_100m,
        .rst_n,
        .sx,
        .sy,
        .hsync,
        .vsync,
        .de,
        .frame,
        .line()             // no line consumer here
    );

    circle_sequencer seq_inst (
        .clk_100m,
        .rst_n,
        .frame,
        .done,
        .job,
        .start,
        .oe,
        .scene_done
    );

    draw_circle draw_inst (
        .clk_100m,
        .rst_n,
        .start,
        .oe,
        .job,
        .cidx(`CIDXW'(`SHAPE_CIDX)),
        .wr,
        .done
    );

    framebuffer fb_inst (
        .clk_100m,
        .rst_n,
        .wr,
        .sx,
        .sy,
        .hsync,
        .vsync,
        .de,
        .video
    );

endmodule

// ==== display_timing.sv ====
//##########################################################
// counters start at 0 on reset, every output lags them by one cycle
// blanking follows the active area, coordinates never go negative
//##########################################################
`include "circles_settings.svh"

module display_timing (
    input  logic                     clk_100m,
    input  logic                     rst_n,
    output logic signed [`CORDW-1:0] sx,
    output logic signed [`CORDW-1:0] sy,
    output logic                     hsync,
    output logic                     vsync,
    output logic                     de,
    output logic                     frame,
    output logic                     line
);
    localparam int H_TOTAL  = `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK;
    localparam int V_TOTAL  = `V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK;
    localparam int HS_START = `H_ACTIVE + `H_FRONT;
    localparam int VS_START = `V_ACTIVE + `V_FRONT;

    logic [`CORDW-1:0] h_cnt;
    logic [`CORDW-1:0] v_cnt;

    always_ff @(posedge clk_100m or negedge rst_n) begin
        if (!rst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == `CORDW'(H_TOTAL - 1)) begin
            h_cnt <= '0;
            v_cnt <= (v_cnt == `CORDW'(V_TOTAL - 1)) ? '0 : v_cnt + 1'b1;  // wrap at frame end
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // registered decodes of the counters
    always_ff @(posedge clk_100m or negedge rst_n) begin
        if (!rst_n) begin
            sx    <= '0;
            sy    <= '0;
            hsync <= 1'b0;
            vsync <= 1'b0;
            de    <= 1'b0;
            frame <= 1'b0;
            line  <= 1'b0;
        end else begin
            sx    <= signed'(h_cnt);
            sy    <= signed'(v_cnt);
            hsync <= (h_cnt >= HS_START) && (h_cnt < HS_START + `H_SYNC);
            vsync <= (v_cnt >= VS_START) && (v_cnt < VS_START + `V_SYNC);  // whole lines
            de    <= (h_cnt < `H_ACTIVE) && (v_cnt < `V_ACTIVE);
            frame <= (h_cnt == '0) && (v_cnt == '0);
            line  <= (h_cnt == '0);
        end
    end

endmodule

// ==== draw_circle.sv ====
//##########################################################
// integer midpoint rule: a=0, b=r0, d=1-r0, plot while a <= b
// the job must stay stable until done, oe low stalls without loss
//##########################################################
`include "circles_settings.svh"

module draw_circle (
    input  logic                   clk_100m,
    input  logic                   rst_n,
    input  logic                   start,
    input  logic                   oe,
    input  circles_pkg::circle_t   job,
    input  logic [`CIDXW-1:0]      cidx,
    output circles_pkg::fb_write_t wr,
    output logic                   done
);
    circles_pkg::circle_state_e state;

    logic signed [`CORDW-1:0] a;        // offset along the octant
    logic signed [`CORDW-1:0] b;        // offset across the octant
    logic signed [`CORDW-1:0] d;        // midpoint error term
    logic signed [`CORDW-1:0] a_nxt;
    logic signed [`CORDW-1:0] b_nxt;
    logic signed [`CORDW-1:0] d_nxt;
    logic signed [`CORDW-1:0] off_u;
    logic signed [`CORDW-1:0] off_v;
    logic signed [`CORDW-1:0] px;
    logic signed [`CORDW-1:0] py;
    logic [2:0]               oct;      // which of the eight points

    // next offset pair and error term
    always_comb begin
        a_nxt = a + 2'sd1;
        if (d < 0) begin
            b_nxt = b;
            d_nxt = `CORDW'(d + 2 * a_nxt + 1);
        end else begin
            b_nxt = b - 2'sd1;
            d_nxt = `CORDW'(d + 2 * (a_nxt - b_nxt) + 1);
        end
    end

    // oct[2] swaps the offsets, oct[1:0] pick the signs
    always_comb begin
        off_u = oct[2] ? b : a;
        off_v = oct[2] ? a : b;
        px    = oct[0] ? job.x0 - off_u : job.x0 + off_u;
        py    = oct[1] ? job.y0 - off_v : job.y0 + off_v;
    end

    always_ff @(posedge clk_100m or negedge rst_n) begin
        if (!rst_n) begin
            state <= circles_pkg::CIRC_IDLE;
            oct   <= '0;
        end else begin
            case (state)
                circles_pkg::CIRC_IDLE: begin
                    if (start) begin
                        state <= circles_pkg::CIRC_CORNER;
                        oct   <= '0;
                    end
                end
                circles_pkg::CIRC_CORNER: begin
                    if (oe) begin
                        oct <= oct + 1'b1;  // wraps to 0 for the next pair
                        if (oct == 3'd7) begin
                            state <= circles_pkg::CIRC_NEXT;
                        end
                    end
                end
                circles_pkg::CIRC_NEXT: begin
                    state <= (a_nxt > b_nxt) ? circles_pkg::CIRC_DONE : circles_pkg::CIRC_CORNER;
                end
                default: state <= circles_pkg::CIRC_IDLE;  // CIRC_DONE
            endcase
        end
    end

    always_ff @(posedge clk_100m) begin
        if (state == circles_pkg::CIRC_IDLE && start) begin
            a <= '0;
            b <= job.r0;
            d <= `CORDW'(1 - job.r0);
        end else if (state == circles_pkg::CIRC_NEXT) begin
            a <= a_nxt;
            b <= b_nxt;
            d <= d_nxt;
        end
    end

    // one pixel per enabled cycle in CORNER
    always_ff @(posedge clk_100m or negedge rst_n) begin
        if (!rst_n) begin
            wr <= '0;
        end else begin
            wr.we   <= (state == circles_pkg::CIRC_CORNER) && oe;
            wr.x    <= px;
            wr.y    <= py;
            wr.cidx <= cidx;
        end
    end

    assign done = (state == circles_pkg::CIRC_DONE);

endmodule

// ==== framebuffer.sv ====
//##########################################################
// reset clears every entry, writes outside the buffer are dropped
// video is two cycles behind the timing inputs, sync and de included
//##########################################################
`include "circles_settings.svh"

module framebuffer (
    input  logic                     clk_100m,
    input  logic                     rst_n,
    input  circles_pkg::fb_write_t   wr,
    input  logic signed [`CORDW-1:0] sx,
    input  logic signed [`CORDW-1:0] sy,
    input  logic                     hsync,
    input  logic                     vsync,
    input  logic                     de,
    output circles_pkg::video_t      video
);
    localparam int FB_DEPTH = `FB_WIDTH * `FB_HEIGHT;
    localparam int ADDRW    = $clog2(FB_DEPTH);

    // 16 entry palette, {red, green, blue}
    localparam logic [3*`CHANW-1:0] PALETTE [16] = '{
        12'h000, 12'h111, 12'h222, 12'h333,
        12'h444, 12'h555, 12'h666, 12'h777,
        12'h888, 12'h999, 12'hAAA, 12'hBBB,
        12'h25F, 12'hDDD, 12'hEEE, 12'hFFF
    };

    logic [`CIDXW-1:0]        mem [FB_DEPTH];
    logic                     wr_ok;
    logic [ADDRW-1:0]         wr_addr;
    logic signed [`CORDW-1:0] rx;
    logic signed [`CORDW-1:0] ry;
    logic                     rd_in;
    logic [ADDRW-1:0]         rd_addr;
    logic [`CIDXW-1:0]        rd_cidx;
    logic                     rd_ok;
    logic                     hsync_p1;
    logic                     vsync_p1;

    // write clipping
    assign wr_ok   = wr.we && (wr.x >= 0) && (wr.x < `FB_WIDTH)
                     && (wr.y >= 0) && (wr.y < `FB_HEIGHT);
    assign wr_addr = ADDRW'(wr.y * `FB_WIDTH + wr.x);

    always_ff @(posedge clk_100m or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < FB_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_ok) begin
            mem[wr_addr] <= wr.cidx;
        end
    end

    // scaled read address
    assign rx      = `CORDW'(sx / `FB_SCALE);
    assign ry      = `CORDW'(sy / `FB_SCALE);
    assign rd_in   = (rx >= 0) && (rx < `FB_WIDTH) && (ry >= 0) && (ry < `FB_HEIGHT);
    assign rd_addr = rd_in ? ADDRW'(ry * `FB_WIDTH + rx) : '0;

    always_ff @(posedge clk_100m) begin
        rd_cidx <= mem[rd_addr];
    end

    always_ff @(posedge clk_100m or negedge rst_n) begin
        if (!rst_n) begin
            hsync_p1 <= 1'b0;
            vsync_p1 <= 1'b0;
            rd_ok    <= 1'b0;
            video    <= '0;
        end else begin
            hsync_p1    <= hsync;
            vsync_p1    <= vsync;
            rd_ok       <= de && rd_in;  // doubles as delayed de
            video.hsync <= hsync_p1;
            video.vsync <= vsync_p1;
            video.de    <= rd_ok;
            if (rd_ok) begin
                {video.red, video.green, video.blue} <= PALETTE[rd_cidx];
            end else begin
                {video.red, video.green, video.blue} <= '0;  // blanking is black
            end
        end
    end

endmodule

// ==== tb_circles.sv ====
//############################################################
// video is compared three cycles behind the timing counters
// expected image comes from a midpoint model, watchdog at 20 frames
//############################################################
module tb_circles;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD  = 10;
    localparam int RST_CYCLES  = 16;
    localparam int H_ACTIVE    = 64;
    localparam int H_TOTAL     = 80;
    localparam int HS_START    = 68;     // active + front porch
    localparam int H_SYNC      = 8;
    localparam int V_ACTIVE    = 48;
    localparam int V_TOTAL     = 54;
    localparam int VS_START    = 50;
    localparam int V_SYNC      = 2;
    localparam int FB_W        = 32;
    localparam int FB_H        = 24;
    localparam int FB_SCALE    = 2;
    localparam int SHAPES      = 4;
    localparam int SHAPE_X0    = 16;
    localparam int SHAPE_Y0    = 12;
    localparam int SHAPE_R0    = 10;
    localparam int SHAPE_RSTEP = 2;
    localparam int FRAME_WAIT  = 3;
    localparam int PIPE_LAT    = 3;      // counter, timing regs, read, palette
    localparam int F_CYCLES    = H_TOTAL * V_TOTAL;
    localparam int WATCHDOG_CYCLES = 20 * F_CYCLES;
    localparam logic [11:0] RGB_SHAPE = 12'h25F;  // palette entry 12
    localparam logic [11:0] RGB_BLACK = 12'h000;  // palette entry 0

    logic                clk_100m = 1'b0;
    logic                rst_n    = 1'b0;
    circles_pkg::video_t video;
    logic                scene_done;

    int          cyc          = 0;  // clock edges since reset release
    int          image_frame  = -1;
    int          img_checked  = 0;
    logic        done_seen    = 1'b0;
    bit          img [FB_W*FB_H];
    logic        pos_ok;
    int          pos;
    int          h_pos;
    int          v_pos;
    int          frame_no;
    int          pix_idx;
    logic        hs_exp;
    logic        vs_exp;
    logic        de_exp;
    logic [11:0] rgb_exp;
    logic [11:0] rgb_act;
    int          err_reset = 0;
    int          err_sync  = 0;
    int          err_blank = 0;
    int          err_done  = 0;
    int          err_image = 0;
    int          err_misc  = 0;

    circles_top dut0 (
        .clk_100m,
        .rst_n,
        .video,
        .scene_done
    );

    always #(CLK_PERIOD/2) clk_100m = ~clk_100m;

    always @(posedge clk_100m) begin
        if (!rst_n) begin
            cyc       <= 0;
            done_seen <= 1'b0;
        end else begin
            cyc <= cyc + 1;
            if (scene_done) done_seen <= 1'b1;
            if (pos_ok && de_exp && frame_no == image_frame) img_checked <= img_checked + 1;
        end
    end

    // expected raster position of the pixel now on the video port
    always_comb begin
        pos_ok   = (cyc >= PIPE_LAT);
        pos      = pos_ok ? cyc - PIPE_LAT : 0;
        h_pos    = pos % H_TOTAL;
        v_pos    = (pos / H_TOTAL) % V_TOTAL;
        frame_no = pos / F_CYCLES;
        hs_exp   = (h_pos >= HS_START) && (h_pos < HS_START + H_SYNC);
        vs_exp   = (v_pos >= VS_START) && (v_pos < VS_START + V_SYNC);
        de_exp   = (h_pos < H_ACTIVE) && (v_pos < V_ACTIVE);
        pix_idx  = de_exp ? (v_pos / FB_SCALE) * FB_W + h_pos / FB_SCALE : 0;
        rgb_exp  = img[pix_idx] ? RGB_SHAPE : RGB_BLACK;
        rgb_act  = {video.red, video.green, video.blue};
    end

    a_reset: assert property (@(posedge clk_100m)
        (rst_n && pos_ok) || (video == '0 && !scene_done))
        else begin
            err_reset++;
            $display("error at %0t ns: video/scene_done expected 0/0, got %h/%b",
                     $time, $sampled(video), $sampled(scene_done));
        end

    a_hsync: assert property (@(posedge clk_100m) disable iff (!rst_n)
        !pos_ok || video.hsync == hs_exp)
        else begin
            err_sync++;
            $display("error at %0t ns: video.hsync expected %b, got %b",
                     $time, $sampled(hs_exp), $sampled(video.hsync));
        end

    a_vsync: assert property (@(posedge clk_100m) disable iff (!rst_n)
        !pos_ok || video.vsync == vs_exp)
        else begin
            err_sync++;
            $display("error at %0t ns: video.vsync expected %b, got %b",
                     $time, $sampled(vs_exp), $sampled(video.vsync));
        end

    a_de: assert property (@(posedge clk_100m) disable iff (!rst_n)
        !pos_ok || video.de == de_exp)
        else begin
            err_sync++;
            $display("error at %0t ns: video.de expected %b, got %b",
                     $time, $sampled(de_exp), $sampled(video.de));
        end

    // blanking is black, and so is the whole wait period
    a_blank: assert property (@(posedge clk_100m) disable iff (!rst_n)
        !pos_ok || (de_exp && frame_no >= FRAME_WAIT) || rgb_act == RGB_BLACK)
        else begin
            err_blank++;
            $display("error at %0t ns: video rgb expected %h, got %h",
                     $time, RGB_BLACK, $sampled(rgb_act));
        end

    a_done_early: assert property (@(posedge clk_100m) disable iff (!rst_n)
        cyc >= FRAME_WAIT * F_CYCLES || !scene_done)
        else begin
            err_done++;
            $display("error at %0t ns: scene_done expected 0, got %b",
                     $time, $sampled(scene_done));
        end

    a_done_sticky: assert property (@(posedge clk_100m) disable iff (!rst_n)
        !done_seen || scene_done)
        else begin
            err_done++;
            $display("error at %0t ns: scene_done expected 1, got %b",
                     $time, $sampled(scene_done));
        end

    a_image: assert property (@(posedge clk_100m) disable iff (!rst_n)
        !pos_ok || frame_no != image_frame || !de_exp || rgb_act == rgb_exp)
        else begin
            err_image++;
            $display("error at %0t ns: video rgb expected %h, got %h",
                     $time, $sampled(rgb_exp), $sampled(rgb_act));
        end

    task automatic plot_point(input int x, input int y);
        if (x >= 0 && x < FB_W && y >= 0 && y < FB_H) img[y*FB_W + x] = 1'b1;
    endtask

    // midpoint circles, union of all shapes
    task automatic draw_reference_circles();
        int r;
        int a;
        int b;
        int d;
        foreach (img[i]) img[i] = 1'b0;
        for (int n = 0; n < SHAPES; n++) begin
            r = SHAPE_R0 - n * SHAPE_RSTEP;
            a = 0;
            b = r;
            d = 1 - r;
            while (a <= b) begin
                plot_point(SHAPE_X0 + a, SHAPE_Y0 + b);
                plot_point(SHAPE_X0 - a, SHAPE_Y0 + b);
                plot_point(SHAPE_X0 + a, SHAPE_Y0 - b);
                plot_point(SHAPE_X0 - a, SHAPE_Y0 - b);
                plot_point(SHAPE_X0 + b, SHAPE_Y0 + a);
                plot_point(SHAPE_X0 - b, SHAPE_Y0 + a);
                plot_point(SHAPE_X0 + b, SHAPE_Y0 - a);
                plot_point(SHAPE_X0 - b, SHAPE_Y0 - a);
                a = a + 1;
                if (d < 0) begin
                    d = d + 2 * a + 1;
                end else begin
                    b = b - 1;
                    d = d + 2 * (a - b) + 1;
                end
            end
        end
    endtask

    function automatic int error_total();
        return err_reset + err_sync + err_blank + err_done + err_image + err_misc;
    endfunction

    task automatic print_summary();
        $write("check summary: reset %0d, sync %0d, blank %0d, ",
               err_reset, err_sync, err_blank);
        $display("scene_done %0d, image %0d, other %0d, total %0d",
                 err_done, err_image, err_misc, error_total());
    endtask

    initial begin
        rst_n = 1'b0;
        draw_reference_circles();
        repeat (RST_CYCLES) @(negedge clk_100m);
        rst_n = 1'b1;
        while (!scene_done) @(negedge clk_100m);  // bounded by the watchdog
        image_frame = (cyc - PIPE_LAT) / F_CYCLES + 1;
        while (cyc < PIPE_LAT + (image_frame + 1) * F_CYCLES + 2) @(negedge clk_100m);
        if (img_checked != H_ACTIVE * V_ACTIVE) begin
            err_misc++;
            $display("final image frame covered %0d of %0d active pixels",
                     img_checked, H_ACTIVE * V_ACTIVE);
        end
        print_summary();
        if (error_total() == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        #((RST_CYCLES + WATCHDOG_CYCLES) * CLK_PERIOD);
        $display("watchdog expired after %0d cycles before the final image was checked",
                 WATCHDOG_CYCLES);
        print_summary();
        $display("tests failed");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+.
circles_pkg.sv
display_timing.sv
draw_circle.sv
framebuffer.sv
circle_sequencer.sv
circles_top.sv
tb_circles.sv
